//--- hdl/audio_mix_pkg.sv
// Shared types for the stereo mixer: sample, sum, attenuation, mix mode, host word, command FSM

package audio_mix_pkg;

	////////////////////////////////
	// Audio data widths
	////////////////////////////////

	// One 16-bit audio sample, raw bits
	typedef logic [15:0] sample_t;

	// Channel sum with one bit of headroom
	typedef logic signed [16:0] sum_t;

	// Bit 4 mutes, bits 3:0 give the right shift
	typedef logic [4:0] att_t;

	// Crossfeed mode between left and right
	typedef logic [1:0] mix_t;

	localparam mix_t MIX_NONE   = 2'd0;
	localparam mix_t MIX_LIGHT  = 2'd1;
	localparam mix_t MIX_MEDIUM = 2'd2;
	localparam mix_t MIX_MONO   = 2'd3;

	////////////////////////////////
	// Host command channel
	////////////////////////////////

	typedef logic [15:0] host_word_t;

	// Command code taken from the low byte of the first word
	typedef logic [7:0] cmd_t;

	typedef enum logic [0:0] {
		CMD_WAIT,
		CMD_DATA
	} cmd_state_t;

endpackage

//--- hdl/host_cmd_decoder.sv
// Host command decoder: strobe edge detect, command FSM and volume attenuation register

`timescale 1ns/100ps

module host_cmd_decoder #(
	parameter audio_mix_pkg::cmd_t VOL_CMD = '0
) (
	input  logic                     clk,
	input  logic                     resetd,
	input  logic                     i_io_uio,
	input  logic                     i_io_strobe,
	input  audio_mix_pkg::host_word_t i_io_din,
	output audio_mix_pkg::att_t       o_vol_att
);

	import audio_mix_pkg::*;

	cmd_state_t state_q;
	cmd_t       cmd_q;
	logic       strobe_q;
	logic       strobe_rise;
	logic       vol_wr;

	// Word is taken on the strobe rising edge only
	assign strobe_rise = i_io_strobe & ~strobe_q;

	// Data word of the volume command
	assign vol_wr = i_io_uio & strobe_rise & (state_q == CMD_DATA) & (cmd_q == VOL_CMD);

	//////////////////////////////
	// Command FSM
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			strobe_q <= 1'b0;
			state_q  <= CMD_WAIT;
			cmd_q    <= '0;
		end else begin
			strobe_q <= i_io_strobe;
			if (!i_io_uio) begin
				// Channel deselected, next word is a command again
				state_q <= CMD_WAIT;
				cmd_q   <= '0;
			end else if (strobe_rise) begin
				case (state_q)
					CMD_WAIT: begin
						cmd_q   <= i_io_din[7:0];
						state_q <= CMD_DATA;
					end
					CMD_DATA: begin
						// Stay here for every further data word
						state_q <= CMD_DATA;
					end
					default: begin
						state_q <= CMD_WAIT;
					end
				endcase
			end
		end
	end

	//////////////////////////////
	// Volume register
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			o_vol_att <= '0;
		end else if (vol_wr) begin
			o_vol_att <= i_io_din[4:0];
		end
	end

endmodule

//--- hdl/channel_sum.sv
// One channel front end: core sample deglitch, unsigned/signed conversion and host PCM sum

`timescale 1ns/100ps

module channel_sum (
	input  logic                  clk,
	input  logic                  resetd,
	input  logic                  i_is_signed,
	input  audio_mix_pkg::sample_t i_core,
	input  audio_mix_pkg::sample_t i_pcm,
	output audio_mix_pkg::sum_t    o_sum
);

	import audio_mix_pkg::*;

	sample_t core_d1;
	sample_t core_d2;
	sample_t core_d3;
	sample_t core_held;
	sum_t    conv_q;
	sum_t    pcm_ext;

	//////////////////////////////
	// Glitch filter
	//////////////////////////////

	// Held sample moves only after two equal stages
	always_ff @(posedge clk) begin
		if (resetd) begin
			core_d1   <= '0;
			core_d2   <= '0;
			core_d3   <= '0;
			core_held <= '0;
		end else begin
			core_d1 <= i_core;
			core_d2 <= core_d1;
			core_d3 <= core_d2;
			if (core_d2 == core_d3) begin
				core_held <= core_d2;
			end
		end
	end

	//////////////////////////////
	// Format and PCM sum
	//////////////////////////////

	// Host PCM is always two's complement
	assign pcm_ext = {i_pcm[15], i_pcm};

	always_ff @(posedge clk) begin
		if (resetd) begin
			conv_q <= '0;
			o_sum  <= '0;
		end else begin
			// Unsigned samples lose one bit to stay positive
			if (i_is_signed) begin
				conv_q <= {core_held[15], core_held};
			end else begin
				conv_q <= {2'b00, core_held[15:1]};
			end
			o_sum <= conv_q + pcm_ext;
		end
	end

endmodule

//--- hdl/stereo_blend.sv
// Stereo blend: crossfeed between channel sums, attenuation, mute and 16-bit clamp

`timescale 1ns/100ps

module stereo_blend (
	input  logic                  clk,
	input  logic                  resetd,
	input  audio_mix_pkg::mix_t    i_mix,
	input  audio_mix_pkg::att_t    i_att,
	input  audio_mix_pkg::sum_t    i_sum_l,
	input  audio_mix_pkg::sum_t    i_sum_r,
	output audio_mix_pkg::sample_t o_audio_l,
	output audio_mix_pkg::sample_t o_audio_r
);

	import audio_mix_pkg::*;

	// Pre-mix halves, each feeds the other channel
	sample_t half_l;
	sample_t half_r;

	sum_t xf_l;
	sum_t xf_r;
	sum_t lvl_l;
	sum_t lvl_r;

	// Own sum s blended with the other channel's half p
	function automatic sum_t crossfeed(input sum_t s, input sample_t p, input mix_t mode);
		sum_t p_ext;
		p_ext = {p[15], p};
		case (mode)
			MIX_LIGHT:  return s - (s >>> 3) + (p_ext >>> 2);
			MIX_MEDIUM: return s - (s >>> 2) + (p_ext >>> 1);
			MIX_MONO:   return (s >>> 1) + p_ext;
			default:    return s;
		endcase
	endfunction

	// Saturate when bits 16 and 15 disagree
	function automatic sample_t clamp16(input sum_t v);
		if (v[16] != v[15]) begin
			return v[16] ? 16'h8000 : 16'h7fff;
		end
		return v[15:0];
	endfunction

	//////////////////////////////
	// Crossfeed stage
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			half_l <= '0;
			half_r <= '0;
			xf_l   <= '0;
			xf_r   <= '0;
		end else begin
			half_l <= i_sum_l[16:1];
			half_r <= i_sum_r[16:1];
			xf_l   <= crossfeed(i_sum_l, half_r, i_mix);
			xf_r   <= crossfeed(i_sum_r, half_l, i_mix);
		end
	end

	//////////////////////////////
	// Attenuation and clamp
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			lvl_l <= '0;
			lvl_r <= '0;
		end else if (i_att[4]) begin
			// Mute
			lvl_l <= '0;
			lvl_r <= '0;
		end else begin
			lvl_l <= xf_l >>> i_att[3:0];
			lvl_r <= xf_r >>> i_att[3:0];
		end
	end

	always_ff @(posedge clk) begin
		if (resetd) begin
			o_audio_l <= '0;
			o_audio_r <= '0;
		end else begin
			o_audio_l <= clamp16(lvl_l);
			o_audio_r <= clamp16(lvl_r);
		end
	end

endmodule

//--- hdl/audio_mixer_top.sv
// Stereo audio mixer top level: host command decoder, two channel fronts and the blend

`timescale 1ns/100ps

module audio_mixer_top #(
	parameter audio_mix_pkg::cmd_t VOL_CMD = 8'h26
) (
	input  logic                     clk,
	input  logic                     resetd,
	input  logic                     i_is_signed,
	input  audio_mix_pkg::mix_t       i_mix,
	input  audio_mix_pkg::sample_t    i_core_l,
	input  audio_mix_pkg::sample_t    i_core_r,
	input  audio_mix_pkg::sample_t    i_pcm_l,
	input  audio_mix_pkg::sample_t    i_pcm_r,
	input  logic                     i_io_uio,
	input  logic                     i_io_strobe,
	input  audio_mix_pkg::host_word_t i_io_din,
	output audio_mix_pkg::sample_t    o_audio_l,
	output audio_mix_pkg::sample_t    o_audio_r
);

	import audio_mix_pkg::*;

	att_t vol_att;
	sum_t sum_l;
	sum_t sum_r;

	// Volume from the host command stream
	host_cmd_decoder #(
		.VOL_CMD(VOL_CMD)
	) u_cmd (
		.clk        (clk),
		.resetd     (resetd),
		.i_io_uio   (i_io_uio),
		.i_io_strobe(i_io_strobe),
		.i_io_din   (i_io_din),
		.o_vol_att  (vol_att)
	);

	channel_sum u_sum_l (
		.clk        (clk),
		.resetd     (resetd),
		.i_is_signed(i_is_signed),
		.i_core     (i_core_l),
		.i_pcm      (i_pcm_l),
		.o_sum      (sum_l)
	);

	channel_sum u_sum_r (
		.clk        (clk),
		.resetd     (resetd),
		.i_is_signed(i_is_signed),
		.i_core     (i_core_r),
		.i_pcm      (i_pcm_r),
		.o_sum      (sum_r)
	);

	stereo_blend u_blend (
		.clk      (clk),
		.resetd   (resetd),
		.i_mix    (i_mix),
		.i_att    (vol_att),
		.i_sum_l  (sum_l),
		.i_sum_r  (sum_r),
		.o_audio_l(o_audio_l),
		.o_audio_r(o_audio_r)
	);

endmodule

//--- bench/audio_mixer_assert.sv
// Concurrent checks on the mixer outputs: reset value, known values, steady state

`timescale 1ns/100ps

module audio_mixer_assert (
	input logic                      clk,
	input logic                      resetd,
	input logic                      i_is_signed,
	input audio_mix_pkg::mix_t       i_mix,
	input audio_mix_pkg::sample_t    i_core_l,
	input audio_mix_pkg::sample_t    i_core_r,
	input audio_mix_pkg::sample_t    i_pcm_l,
	input audio_mix_pkg::sample_t    i_pcm_r,
	input logic                      i_io_uio,
	input logic                      i_io_strobe,
	input audio_mix_pkg::host_word_t i_io_din,
	input audio_mix_pkg::sample_t    o_audio_l,
	input audio_mix_pkg::sample_t    o_audio_r
);

	import audio_mix_pkg::*;

	logic        reset_seen;
	logic [84:0] in_bus;
	logic [84:0] in_q;
	logic [3:0]  stable_cnt;
	int          fail_cnt;

	assign in_bus = {i_is_signed, i_mix, i_core_l, i_core_r, i_pcm_l, i_pcm_r,
			i_io_uio, i_io_strobe, i_io_din};

	initial reset_seen = 1'b0;
	initial fail_cnt = 0;

	// Cycles with all inputs unchanged, saturating
	always @(posedge clk) begin
		in_q <= in_bus;
		if (resetd) begin
			reset_seen <= 1'b1;
			stable_cnt <= '0;
		end else if (in_bus != in_q) begin
			stable_cnt <= '0;
		end else if (stable_cnt != 4'd15) begin
			stable_cnt <= stable_cnt + 4'd1;
		end
	end

	a_reset_zero: assert property (@(posedge clk)
		resetd |=> (o_audio_l == '0 && o_audio_r == '0))
		else begin
			fail_cnt++;
			$error("Outputs not zero in the cycle after reset");
		end

	a_known: assert property (@(posedge clk) disable iff (resetd)
		reset_seen |-> !$isunknown({o_audio_l, o_audio_r}))
		else begin
			fail_cnt++;
			$error("Output is unknown after reset");
		end

	a_steady: assert property (@(posedge clk) disable iff (resetd)
		(stable_cnt >= 4'd12) |=> ($stable(o_audio_l) && $stable(o_audio_r)))
		else begin
			fail_cnt++;
			$error("Outputs changed while inputs were steady");
		end

endmodule

bind audio_mixer_top audio_mixer_assert u_assert (
	.clk        (clk),
	.resetd     (resetd),
	.i_is_signed(i_is_signed),
	.i_mix      (i_mix),
	.i_core_l   (i_core_l),
	.i_core_r   (i_core_r),
	.i_pcm_l    (i_pcm_l),
	.i_pcm_r    (i_pcm_r),
	.i_io_uio   (i_io_uio),
	.i_io_strobe(i_io_strobe),
	.i_io_din   (i_io_din),
	.o_audio_l  (o_audio_l),
	.o_audio_r  (o_audio_r)
);

//--- bench/audio_mixer_tb.sv
// Mixer testbench: clock, reset, reference model, compare tasks and directed tests

`timescale 1ns/100ps

module audio_mixer_tb;

	import audio_mix_pkg::*;

	localparam int SETTLE_CYCLES  = 12;
	localparam int STABLE_TIMEOUT = 20;

	logic       clk;
	logic       resetd;
	logic       i_is_signed;
	mix_t       i_mix;
	sample_t    i_core_l;
	sample_t    i_core_r;
	sample_t    i_pcm_l;
	sample_t    i_pcm_r;
	logic       i_io_uio;
	logic       i_io_strobe;
	host_word_t i_io_din;
	sample_t    o_audio_l;
	sample_t    o_audio_r;

	int checks;
	int errors;

	audio_mixer_top audio_mixer_top_inst (
		.clk        (clk),
		.resetd     (resetd),
		.i_is_signed(i_is_signed),
		.i_mix      (i_mix),
		.i_core_l   (i_core_l),
		.i_core_r   (i_core_r),
		.i_pcm_l    (i_pcm_l),
		.i_pcm_r    (i_pcm_r),
		.i_io_uio   (i_io_uio),
		.i_io_strobe(i_io_strobe),
		.i_io_din   (i_io_din),
		.o_audio_l  (o_audio_l),
		.o_audio_r  (o_audio_r)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	//////////////////////////////
	// Reference model
	//////////////////////////////

	// Channel sum in steady state
	function automatic int chan_sum(input sample_t core, input sample_t pcm, input logic sgn);
		int c;
		if (sgn) begin
			c = int'($signed(core));
		end else begin
			c = int'(core >> 1);
		end
		return c + int'($signed(pcm));
	endfunction

	// Wrap to the 17-bit signed range
	function automatic int wrap17(input int v);
		int w;
		w = v & 32'h1ffff;
		if (w[16]) begin
			w = w - 131072;
		end
		return w;
	endfunction

	function automatic sample_t expect_out(input int s, input int s_other, input mix_t mode,
			input att_t att);
		int p;
		int x;
		int y;
		p = s_other >>> 1;
		case (mode)
			MIX_LIGHT:  x = s - (s >>> 3) + (p >>> 2);
			MIX_MEDIUM: x = s - (s >>> 2) + (p >>> 1);
			MIX_MONO:   x = (s >>> 1) + p;
			default:    x = s;
		endcase
		x = wrap17(x);
		if (att[4]) begin
			y = 0;
		end else begin
			y = x >>> att[3:0];
		end
		if (y > 32767) begin
			return 16'h7fff;
		end
		if (y < -32768) begin
			return 16'h8000;
		end
		return y[15:0];
	endfunction

	function automatic sample_t rand16();
		logic [31:0] r;
		r = $urandom;
		return r[15:0];
	endfunction

	//////////////////////////////
	// Compare tasks
	//////////////////////////////

	task automatic check_sample(input string name, input sample_t got, input sample_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED time=%0t %s got=%h expected=%h", $time, name, got, exp);
		end
	endtask

	task automatic check_att(input string name, input att_t got, input att_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED time=%0t %s got=%h expected=%h", $time, name, got, exp);
		end
	endtask

	task automatic report_test(input string name, input int err_start, input int chk_start);
		$display("%-14s %0d checks, %0d errors", name, checks - chk_start, errors - err_start);
	endtask

	//////////////////////////////
	// Drive and wait
	//////////////////////////////

	task automatic drive(input logic sgn, input mix_t mode, input sample_t cl, input sample_t cr,
			input sample_t pl, input sample_t pr);
		@(posedge clk);
		#1;
		i_is_signed = sgn;
		i_mix       = mode;
		i_core_l    = cl;
		i_core_r    = cr;
		i_pcm_l     = pl;
		i_pcm_r     = pr;
	endtask

	// Pipeline latency, then outputs must hold still
	task automatic wait_settle();
		sample_t prev_l;
		sample_t prev_r;
		logic    done;
		int      n;
		for (n = 0; n < SETTLE_CYCLES; n++) begin
			@(negedge clk);
		end
		prev_l = o_audio_l;
		prev_r = o_audio_r;
		done   = 1'b0;
		for (n = 0; n < STABLE_TIMEOUT && !done; n++) begin
			@(negedge clk);
			if (o_audio_l === prev_l && o_audio_r === prev_r) begin
				done = 1'b1;
			end
			prev_l = o_audio_l;
			prev_r = o_audio_r;
		end
		if (!done) begin
			errors++;
			$display("Outputs did not settle within %0d cycles at time %0t", STABLE_TIMEOUT, $time);
		end
	endtask

	task automatic check_mix(input logic sgn, input mix_t mode, input sample_t cl,
			input sample_t cr, input sample_t pl, input sample_t pr, input att_t att);
		int s_l;
		int s_r;
		drive(sgn, mode, cl, cr, pl, pr);
		wait_settle();
		s_l = chan_sum(cl, pl, sgn);
		s_r = chan_sum(cr, pr, sgn);
		check_sample("o_audio_l", o_audio_l, expect_out(s_l, s_r, mode, att));
		check_sample("o_audio_r", o_audio_r, expect_out(s_r, s_l, mode, att));
	endtask

	task automatic host_select(input logic lvl);
		@(posedge clk);
		#1;
		i_io_uio = lvl;
		@(posedge clk);
	endtask

	// One word, strobe held high for two clocks
	task automatic host_word(input host_word_t w);
		@(posedge clk);
		#1;
		i_io_din    = w;
		i_io_strobe = 1'b1;
		repeat (2) @(posedge clk);
		#1;
		i_io_strobe = 1'b0;
		repeat (2) @(posedge clk);
	endtask

	//////////////////////////////
	// Directed tests
	//////////////////////////////

	task automatic test_reset();
		int e0;
		int c0;
		e0 = errors;
		c0 = checks;
		@(negedge clk);
		check_sample("o_audio_l", o_audio_l, 16'h0000);
		check_sample("o_audio_r", o_audio_r, 16'h0000);
		check_att("vol_att", audio_mixer_top_inst.vol_att, 5'h00);
		report_test("reset", e0, c0);
	endtask

	task automatic test_format();
		sample_t cl;
		sample_t cr;
		int      e0;
		int      c0;
		int      n;
		e0 = errors;
		c0 = checks;
		for (n = 0; n < 8; n++) begin
			cl = rand16();
			cr = rand16();
			drive(n[0], MIX_NONE, cl, cr, 16'h0000, 16'h0000);
			wait_settle();
			// Signed passes through, unsigned loses its lowest bit
			check_sample("o_audio_l", o_audio_l, n[0] ? cl : (cl >> 1));
			check_sample("o_audio_r", o_audio_r, n[0] ? cr : (cr >> 1));
		end
		report_test("format", e0, c0);
	endtask

	task automatic test_pcm_sat();
		int e0;
		int c0;
		int n;
		e0 = errors;
		c0 = checks;
		for (n = 0; n < 4; n++) begin
			check_mix(n[0], MIX_NONE, rand16(), rand16(), rand16(), rand16(), 5'h00);
		end
		drive(1'b1, MIX_NONE, 16'h7000, 16'h9000, 16'h7000, 16'h9000);
		wait_settle();
		check_sample("o_audio_l", o_audio_l, 16'h7fff);
		check_sample("o_audio_r", o_audio_r, 16'h8000);
		report_test("pcm_sat", e0, c0);
	endtask

	task automatic test_crossfeed();
		mix_t mode;
		int   e0;
		int   c0;
		int   n;
		e0 = errors;
		c0 = checks;
		for (n = 0; n < 9; n++) begin
			mode = mix_t'(n / 3 + 1);
			check_mix(1'b1, mode, rand16(), rand16(), rand16(), rand16(), 5'h00);
		end
		report_test("crossfeed", e0, c0);
	endtask

	task automatic test_volume();
		sample_t cl;
		sample_t cr;
		sample_t pl;
		sample_t pr;
		int      e0;
		int      c0;
		e0 = errors;
		c0 = checks;
		cl = rand16();
		cr = rand16();
		pl = rand16();
		pr = rand16();
		host_select(1'b1);
		host_word(16'h0026);
		host_word(16'h0003);
		check_att("vol_att", audio_mixer_top_inst.vol_att, 5'h03);
		check_mix(1'b1, MIX_MEDIUM, cl, cr, pl, pr, 5'h03);
		// Still in the data phase, so this one mutes
		host_word(16'h0010);
		wait_settle();
		check_sample("o_audio_l", o_audio_l, 16'h0000);
		check_sample("o_audio_r", o_audio_r, 16'h0000);
		// Other command, its data must not touch the volume
		host_select(1'b0);
		host_select(1'b1);
		host_word(16'h0011);
		host_word(16'h0004);
		host_word(16'h0026);
		host_word(16'h0002);
		check_att("vol_att", audio_mixer_top_inst.vol_att, 5'h10);
		// Reselect, first word is a command again
		host_select(1'b0);
		host_select(1'b1);
		host_word(16'h0026);
		host_word(16'h0005);
		check_att("vol_att", audio_mixer_top_inst.vol_att, 5'h05);
		check_mix(1'b1, MIX_LIGHT, cl, cr, pl, pr, 5'h05);
		host_select(1'b0);
		report_test("volume", e0, c0);
	endtask

	//////////////////////////////
	// Run
	//////////////////////////////

	initial begin
		#100000;
		$display("Simulation timed out before the tests finished");
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		checks      = 0;
		errors      = 0;
		void'($urandom(32'h346b));
		resetd      = 1'b1;
		i_is_signed = 1'b1;
		i_mix       = MIX_NONE;
		i_core_l    = '0;
		i_core_r    = '0;
		i_pcm_l     = '0;
		i_pcm_r     = '0;
		i_io_uio    = 1'b0;
		i_io_strobe = 1'b0;
		i_io_din    = '0;
		repeat (3) @(posedge clk);
		#1;
		resetd = 1'b0;
		test_reset();
		test_format();
		test_pcm_sat();
		test_crossfeed();
		test_volume();
		if (audio_mixer_top_inst.u_assert.fail_cnt != 0) begin
			errors += audio_mixer_top_inst.u_assert.fail_cnt;
			$display("Output checker saw %0d assertion failures",
					audio_mixer_top_inst.u_assert.fail_cnt);
		end
		$display("Total %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

//--- audio_mixer_top.f
hdl/audio_mix_pkg.sv
hdl/host_cmd_decoder.sv
hdl/channel_sum.sv
hdl/stereo_blend.sv
hdl/audio_mixer_top.sv
bench/audio_mixer_assert.sv
bench/audio_mixer_tb.sv

//--- Makefile
TB_TOP = audio_mixer_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f audio_mixer_top.f --top-module $(TB_TOP) -o V$(TB_TOP)
	./obj_dir/V$(TB_TOP) | tee sim.log
	grep -q "=== PASS ===" sim.log

lint:
	verilator --lint-only --timing -f audio_mixer_top.f --top-module $(TB_TOP)

clean:
	rm -rf obj_dir sim.log
